//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_input_layer_streamer
RTL_TOP    := input_layer_streamer
FILELIST   := filelist.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
SRCS       := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
src/stream_cfg_pkg.sv
src/axi_rd_pkg.sv
src/scan_sequencer.sv
src/row_fetcher.sv
src/row_window_buffer.sv
src/input_layer_streamer.sv
tb/tb_clock_gen.sv
tb/tb_input_layer_streamer.sv

//--- src/axi_rd_pkg.sv
package axi_rd_pkg;

	// --------------------------------------------------
	// AXI4 read address channel payload
	// --------------------------------------------------
	typedef struct packed {
		logic [31:0] addr;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
	} axi_ar_t;

	// read data channel payload
	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
		logic        last;
	} axi_r_t;

	// one row is 64 bytes, eight 8-byte beats
	localparam int BEATS_PER_ROW = 8;

	// arsize code for 8 bytes per beat
	localparam logic [2:0] AXI_SIZE_8B = 3'd3;
	// incrementing burst
	localparam logic [1:0] AXI_BURST_INCR = 2'd1;

endpackage

//--- src/input_layer_streamer.sv
`timescale 1ns/1ps

module input_layer_streamer #(
	parameter int LAYER_SHIFT = 12,
	parameter int ROW_SHIFT = 6
) (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        start,
	input  stream_cfg_pkg::layer_cfg_t  cfg,
	output axi_rd_pkg::axi_ar_t         ar,
	output logic                        arvalid,
	input  logic                        arready,
	input  axi_rd_pkg::axi_r_t          r,
	input  logic                        rvalid,
	output logic                        rready,
	output stream_cfg_pkg::window_t     win,
	output logic                        win_valid,
	input  logic                        win_ready,
	output logic                        done
);
	import stream_cfg_pkg::*;

	// sequencer to fetcher
	logic        fetch_req;
	slot_sel_t   fetch_slot;
	logic [9:0]  fetch_layer;
	logic [9:0]  fetch_row;
	logic        fetch_done;
	// slot writes and clears
	logic        wr_en;
	slot_sel_t   wr_slot;
	logic [2:0]  wr_beat;
	logic [63:0] wr_data;
	logic        clear_req;
	slot_sel_t   clear_slot;
	// window read
	logic [6:0]  win_col;
	logic [71:0] window_data;

	scan_sequencer i_scan_sequencer (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.cfg         (cfg),
		.fetch_done  (fetch_done),
		.window_data (window_data),
		.win_ready   (win_ready),
		.fetch_req   (fetch_req),
		.fetch_slot  (fetch_slot),
		.fetch_layer (fetch_layer),
		.fetch_row   (fetch_row),
		.clear_req   (clear_req),
		.clear_slot  (clear_slot),
		.win_col     (win_col),
		.win         (win),
		.win_valid   (win_valid),
		.done        (done)
	);

	// base address comes straight from cfg, held by the host for the run
	row_fetcher #(
		.LAYER_SHIFT (LAYER_SHIFT),
		.ROW_SHIFT   (ROW_SHIFT)
	) i_row_fetcher (
		.clk         (clk),
		.reset_n     (reset_n),
		.base_addr   (cfg.base_addr),
		.fetch_req   (fetch_req),
		.fetch_slot  (fetch_slot),
		.fetch_layer (fetch_layer),
		.fetch_row   (fetch_row),
		.ar          (ar),
		.arvalid     (arvalid),
		.arready     (arready),
		.r           (r),
		.rvalid      (rvalid),
		.rready      (rready),
		.fetch_done  (fetch_done),
		.wr_en       (wr_en),
		.wr_slot     (wr_slot),
		.wr_beat     (wr_beat),
		.wr_data     (wr_data)
	);

	row_window_buffer i_row_window_buffer (
		.clk         (clk),
		.reset_n     (reset_n),
		.wr_en       (wr_en),
		.wr_slot     (wr_slot),
		.wr_beat     (wr_beat),
		.wr_data     (wr_data),
		.clear_req   (clear_req),
		.clear_slot  (clear_slot),
		.win_col     (win_col),
		.window_data (window_data)
	);

endmodule

//--- src/row_fetcher.sv
`timescale 1ns/1ps

module row_fetcher #(
	parameter int LAYER_SHIFT = 12,
	parameter int ROW_SHIFT = 6
) (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic [31:0]                base_addr,
	input  logic                       fetch_req,
	input  stream_cfg_pkg::slot_sel_t  fetch_slot,
	input  logic [9:0]                 fetch_layer,
	input  logic [9:0]                 fetch_row,
	output axi_rd_pkg::axi_ar_t        ar,
	output logic                       arvalid,
	input  logic                       arready,
	input  axi_rd_pkg::axi_r_t         r,
	input  logic                       rvalid,
	output logic                       rready,
	output logic                       fetch_done,
	output logic                       wr_en,
	output stream_cfg_pkg::slot_sel_t  wr_slot,
	output logic [2:0]                 wr_beat,
	output logic [63:0]                wr_data
);
	import stream_cfg_pkg::*;
	import axi_rd_pkg::*;

	logic [31:0] req_addr;
	// requests that arrive while a burst is running
	logic [31:0] q_addr [4];
	slot_sel_t   q_slot [4];
	logic [1:0]  q_rd_ptr;
	logic [1:0]  q_wr_ptr;
	logic [2:0]  q_count;
	logic        from_queue;
	logic        load;
	logic        push;
	logic        pop;
	slot_sel_t   cur_slot;
	logic [2:0]  beat_cnt;
	logic        beat_xfer;

	// layer stride plus row stride on top of the base
	assign req_addr = base_addr + (32'(fetch_layer) << LAYER_SHIFT) + (32'(fetch_row) << ROW_SHIFT);

	// start a burst only when both channels are quiet
	assign from_queue = q_count != 3'd0;
	assign load = !arvalid && !rready && (fetch_req || from_queue);
	assign pop = load && from_queue;
	// idle fetcher takes the request straight, else queue it
	assign push = fetch_req && !(load && !from_queue);

	always_ff @(posedge clk) begin
		if (push) begin
			q_addr[q_wr_ptr] <= req_addr;
			q_slot[q_wr_ptr] <= fetch_slot;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			q_rd_ptr <= '0;
			q_wr_ptr <= '0;
			q_count <= '0;
		end else begin
			if (push) begin
				q_wr_ptr <= q_wr_ptr + 2'd1;
			end
			if (pop) begin
				q_rd_ptr <= q_rd_ptr + 2'd1;
			end
			q_count <= q_count + 3'(push) - 3'(pop);
		end
	end

	// --------------------------------------------------
	// AR and R channel control
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (load) begin
			ar.addr <= from_queue ? q_addr[q_rd_ptr] : req_addr;
			ar.len <= 8'(BEATS_PER_ROW - 1);
			ar.size <= AXI_SIZE_8B;
			ar.burst <= AXI_BURST_INCR;
			cur_slot <= from_queue ? q_slot[q_rd_ptr] : fetch_slot;
		end
	end

	assign beat_xfer = rvalid && rready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			arvalid <= 1'b0;
			rready <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (load) begin
				arvalid <= 1'b1;
			end else if (arready) begin
				arvalid <= 1'b0;
			end
			if (arvalid && arready) begin
				rready <= 1'b1;
				beat_cnt <= '0;
			end else if (beat_xfer) begin
				beat_cnt <= beat_cnt + 3'd1;
				if (r.last) begin
					rready <= 1'b0;
				end
			end
		end
	end

	// each beat lands straight in the chosen slot
	assign wr_en = beat_xfer;
	assign wr_slot = cur_slot;
	assign wr_beat = beat_cnt;
	assign wr_data = r.data;
	assign fetch_done = beat_xfer && r.last;

	a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		arvalid && !arready |=> arvalid && $stable(ar));

	// slave must close the burst on the eighth beat
	a_rlast_beat: assert property (@(posedge clk) disable iff (!reset_n)
		beat_xfer |-> r.last == (beat_cnt == 3'(BEATS_PER_ROW - 1)));

endmodule

//--- src/row_window_buffer.sv
`timescale 1ns/1ps

module row_window_buffer (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       wr_en,
	input  stream_cfg_pkg::slot_sel_t  wr_slot,
	input  logic [2:0]                 wr_beat,
	input  logic [63:0]                wr_data,
	input  logic                       clear_req,
	input  stream_cfg_pkg::slot_sel_t  clear_slot,
	input  logic [6:0]                 win_col,
	output logic [71:0]                window_data
);
	import stream_cfg_pkg::*;

	// one 64-byte row per slot, byte k at index k
	logic [7:0] row_mem [WINDOW_ROWS][ROW_BYTES];
	logic [5:0] col_mid;
	logic [5:0] col_prev;
	logic [5:0] col_next;
	logic       has_prev;
	logic       has_next;

	// --------------------------------------------------
	// slot write and clear
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		for (int s = 0; s < WINDOW_ROWS; s++) begin
			for (int k = 0; k < ROW_BYTES; k++) begin
				if (clear_req && clear_slot == slot_sel_t'(s)) begin
					// row outside the layer reads as zeros
					row_mem[s][k] <= 8'h00;
				end else if (wr_en && wr_slot == slot_sel_t'(s) && k[5:3] == wr_beat) begin
					// little-endian lanes, byte k%8 of the beat
					row_mem[s][k] <= wr_data[k[2:0] * 8 +: 8];
				end
			end
		end
	end

	// --------------------------------------------------
	// window gather, zero outside the row
	// --------------------------------------------------
	assign col_mid = win_col[5:0];
	assign col_prev = col_mid - 6'd1;
	assign col_next = col_mid + 6'd1;
	assign has_prev = win_col != 7'd0;
	assign has_next = win_col < 7'(ROW_BYTES - 1);

	always_comb begin
		window_data = '0;
		for (int s = 0; s < WINDOW_ROWS; s++) begin
			// top slot fills the upper 24 bits
			if (has_prev) begin
				window_data[(WINDOW_ROWS - 1 - s) * 24 + 16 +: 8] = row_mem[s][col_prev];
			end
			window_data[(WINDOW_ROWS - 1 - s) * 24 + 8 +: 8] = row_mem[s][col_mid];
			if (has_next) begin
				window_data[(WINDOW_ROWS - 1 - s) * 24 +: 8] = row_mem[s][col_next];
			end
		end
	end

	// sequencer only clears slots it does not fetch into
	a_wr_clear: assert property (@(posedge clk) disable iff (!reset_n)
		!(wr_en && clear_req && wr_slot == clear_slot));

endmodule

//--- src/scan_sequencer.sv
`timescale 1ns/1ps

module scan_sequencer (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        start,
	input  stream_cfg_pkg::layer_cfg_t  cfg,
	input  logic                        fetch_done,
	input  logic [71:0]                 window_data,
	input  logic                        win_ready,
	output logic                        fetch_req,
	output stream_cfg_pkg::slot_sel_t   fetch_slot,
	output logic [9:0]                  fetch_layer,
	output logic [9:0]                  fetch_row,
	output logic                        clear_req,
	output stream_cfg_pkg::slot_sel_t   clear_slot,
	output logic [6:0]                  win_col,
	output stream_cfg_pkg::window_t     win,
	output logic                        win_valid,
	output logic                        done
);
	import stream_cfg_pkg::*;

	layer_cfg_t  cfg_q;
	scan_state_t state;
	logic [9:0]  row_cnt;
	logic [9:0]  layer_cnt;
	// column of the next window to load
	logic [6:0]  col_cnt;
	logic [1:0]  prep_idx;
	// fetches issued but not yet finished
	logic [1:0]  fetch_cnt;
	logic [9:0]  src_row;
	logic        src_valid;
	logic        idle_or_done;
	logic        win_xfer;
	logic        load_win;
	logic        pass_end;
	logic        last_layer;
	logic        last_row;

	assign idle_or_done = (state == st_idle) || (state == st_done);
	assign win_xfer = win_valid && win_ready;
	assign last_layer = layer_cnt == cfg_q.num_layers - 10'd1;
	assign last_row = row_cnt == cfg_q.num_rows - 10'd1;

	// --------------------------------------------------
	// per-slot source row, r-1 / r / r+1
	// --------------------------------------------------
	always_comb begin
		src_row = row_cnt + 10'(prep_idx) - 10'd1;
		case (prep_idx)
			// above the layer on the first row
			2'd0:    src_valid = row_cnt != 10'd0;
			// below the layer on the last row
			2'd2:    src_valid = (row_cnt + 10'd1) < cfg_q.num_rows;
			default: src_valid = 1'b1;
		endcase
	end

	// one action per slot per prep cycle
	assign fetch_req = (state == st_prep) && src_valid;
	assign clear_req = (state == st_prep) && !src_valid;
	assign fetch_slot = slot_sel_t'(prep_idx);
	assign clear_slot = slot_sel_t'(prep_idx);
	assign fetch_layer = layer_cnt;
	assign fetch_row = src_row;

	// --------------------------------------------------
	// window stream
	// --------------------------------------------------
	assign win_col = col_cnt;
	// refill when empty or when the held window leaves
	assign load_win = (state == st_stream) && (col_cnt != cfg_q.num_cols) && (!win_valid || win_ready);
	assign pass_end = (state == st_stream) && win_xfer && (col_cnt == cfg_q.num_cols);
	assign done = state == st_done;

	always_ff @(posedge clk) begin
		if (start && idle_or_done) begin
			cfg_q <= cfg;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= st_idle;
			row_cnt <= '0;
			layer_cnt <= '0;
			col_cnt <= '0;
			prep_idx <= '0;
			fetch_cnt <= '0;
		end else begin
			fetch_cnt <= fetch_cnt + 2'(fetch_req) - 2'(fetch_done);
			case (state)
				st_idle, st_done: begin
					if (start) begin
						row_cnt <= '0;
						layer_cnt <= '0;
						col_cnt <= '0;
						prep_idx <= '0;
						state <= st_prep;
					end
				end
				st_prep: begin
					if (prep_idx == 2'(WINDOW_ROWS - 1)) begin
						prep_idx <= '0;
						state <= st_wait_fetch;
					end else begin
						prep_idx <= prep_idx + 2'd1;
					end
				end
				st_wait_fetch: begin
					// all three slots written or cleared
					if (fetch_cnt == 2'd0) begin
						state <= st_stream;
					end
				end
				st_stream: begin
					if (load_win) begin
						col_cnt <= col_cnt + 7'd1;
					end
					// layer is the middle loop, row the outer one
					if (pass_end) begin
						col_cnt <= '0;
						if (!last_layer) begin
							layer_cnt <= layer_cnt + 10'd1;
							state <= st_prep;
						end else if (!last_row) begin
							layer_cnt <= '0;
							row_cnt <= row_cnt + 10'd1;
							state <= st_prep;
						end else begin
							state <= st_done;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			win_valid <= 1'b0;
		end else if (load_win) begin
			win_valid <= 1'b1;
		end else if (win_xfer) begin
			win_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load_win) begin
			win.data <= window_data;
			win.layer_id <= layer_cnt;
			win.row_id <= row_cnt;
			win.col_id <= 10'(col_cnt);
		end
	end

	// stalled window must not move
	a_win_hold: assert property (@(posedge clk) disable iff (!reset_n)
		win_valid && !win_ready |=> win_valid && $stable(win));

	// a row is one 64-byte burst
	a_cols_range: assert property (@(posedge clk) disable iff (!reset_n)
		start && idle_or_done |-> cfg.num_cols >= 7'd1 && cfg.num_cols <= 7'd64);

endmodule

//--- src/stream_cfg_pkg.sv
package stream_cfg_pkg;

	// --------------------------------------------------
	// run configuration, sampled on start
	// --------------------------------------------------
	typedef struct packed {
		logic [31:0] base_addr;
		logic [9:0]  num_layers;
		logic [9:0]  num_rows;
		// up to 64 columns, one burst per row
		logic [6:0]  num_cols;
	} layer_cfg_t;

	// one 3x3 window with its position tags
	// data is top row in [71:48], middle in [47:24], bottom in [23:0]
	// inside a row, column c-1 sits in the highest byte
	typedef struct packed {
		logic [71:0] data;
		logic [9:0]  layer_id;
		logic [9:0]  row_id;
		logic [9:0]  col_id;
	} window_t;

	// row slot names, top holds row r-1
	typedef enum logic [1:0] {slot_top, slot_mid, slot_bot} slot_sel_t;

	// scan FSM states
	typedef enum logic [2:0] {st_idle, st_prep, st_wait_fetch, st_stream, st_done} scan_state_t;

	// bytes held per row slot
	localparam int ROW_BYTES = 64;
	// rows that make one window
	localparam int WINDOW_ROWS = 3;

endpackage

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset_n
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;
	end

endmodule

//--- tb/tb_input_layer_streamer.sv
`timescale 1ns/1ps

module tb_input_layer_streamer;
	import stream_cfg_pkg::*;
	import axi_rd_pkg::*;

	localparam string PATTERN_FILE = "tb/window_patterns.hex";
	localparam int PATTERN_DEPTH = 256;
	localparam int RANDOM_SEED = 74595;
	localparam logic [31:0] LAYER_STRIDE = 32'd4096;
	localparam logic [31:0] ROW_STRIDE = 32'd64;
	// cycles that done is watched after it rises
	localparam int DONE_HOLD_CYCLES = 5;

	logic       clk;
	logic       reset_n;
	logic       start;
	layer_cfg_t cfg;
	axi_ar_t    ar;
	logic       arvalid;
	logic       arready;
	axi_r_t     r;
	logic       rvalid;
	logic       rready;
	window_t    win;
	logic       win_valid;
	logic       win_ready;
	logic       done;

	// raw pattern lines laid out as in the hex file header
	logic [127:0] pattern_mem [PATTERN_DEPTH];
	// sparse memory image of the current test
	logic [63:0]  mem_words [logic [31:0]];
	window_t      exp_win_q [$];
	logic [31:0]  exp_ar_q [$];
	int           cycle_cnt = 0;
	int           cycle_limit = 0;
	int unsigned  seed_val;

	tb_clock_gen #(
		.PERIOD_NS    (40),
		.RESET_CYCLES (10)
	) i_clock_gen (
		.clk     (clk),
		.reset_n (reset_n)
	);

	input_layer_streamer #(
		.LAYER_SHIFT (12),
		.ROW_SHIFT   (6)
	) i_dut (
		.clk       (clk),
		.reset_n   (reset_n),
		.start     (start),
		.cfg       (cfg),
		.ar        (ar),
		.arvalid   (arvalid),
		.arready   (arready),
		.r         (r),
		.rvalid    (rvalid),
		.rready    (rready),
		.win       (win),
		.win_valid (win_valid),
		.win_ready (win_ready),
		.done      (done)
	);

	// --------------------------------------------------
	// failure reporting and value compare
	// --------------------------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] expected);
		if (actual !== expected) begin
			report_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
				name, actual, expected));
		end
	endtask

	// unlisted addresses read as zero
	function automatic logic [63:0] read_word(input logic [31:0] addr);
		if (mem_words.exists(addr)) begin
			return mem_words[addr];
		end
		return 64'd0;
	endfunction

	// burst addresses in scan order with slots top / mid / bot per pass
	task automatic queue_fetch_order(input layer_cfg_t c);
		int n_rows;
		int n_layers;
		int src;
		n_rows = int'(c.num_rows);
		n_layers = int'(c.num_layers);
		for (int row = 0; row < n_rows; row++) begin
			for (int layer = 0; layer < n_layers; layer++) begin
				for (int s = 0; s < 3; s++) begin
					src = row + s - 1;
					// rows outside the layer are cleared and never fetched
					if (src >= 0 && src < n_rows) begin
						exp_ar_q.push_back(c.base_addr + 32'(layer) * LAYER_STRIDE
							+ 32'(src) * ROW_STRIDE);
					end
				end
			end
		end
	endtask

	task automatic run_test(input layer_cfg_t test_cfg);
		@(posedge clk);
		cfg <= test_cfg;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		// done of the previous run is still seen on this edge
		@(posedge clk);
		while (!done) begin
			@(posedge clk);
		end
		check_value("windows left", 128'(exp_win_q.size()), 128'd0);
		check_value("bursts left", 128'(exp_ar_q.size()), 128'd0);
		// done holds until the next start
		repeat (DONE_HOLD_CYCLES) begin
			@(posedge clk);
			check_value("done", 128'(done), 128'd1);
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		int ptr;
		int num_tests;
		int total_windows;
		int n_mem;
		int n_win;
		logic [127:0] line;
		layer_cfg_t test_cfg;
		window_t exp_w;
		start = 1'b0;
		cfg = '0;
		seed_val = $urandom(RANDOM_SEED);
		$readmemh(PATTERN_FILE, pattern_mem);
		num_tests = int'(pattern_mem[0][15:0]);
		// timeout scales with the number of windows
		ptr = 1;
		total_windows = 0;
		for (int t = 0; t < num_tests; t++) begin
			n_mem = int'(pattern_mem[ptr][47:32]);
			n_win = int'(pattern_mem[ptr][31:16]);
			total_windows += n_win;
			ptr += 1 + n_mem + n_win;
		end
		cycle_limit = 40 * total_windows + 2000;
		wait (reset_n === 1'b1);
		@(posedge clk);
		ptr = 1;
		for (int t = 0; t < num_tests; t++) begin
			line = pattern_mem[ptr];
			test_cfg.base_addr = line[127:96];
			test_cfg.num_layers = line[89:80];
			test_cfg.num_rows = line[73:64];
			test_cfg.num_cols = line[54:48];
			n_mem = int'(line[47:32]);
			n_win = int'(line[31:16]);
			ptr++;
			mem_words.delete();
			for (int i = 0; i < n_mem; i++) begin
				mem_words[pattern_mem[ptr][127:96]] = pattern_mem[ptr][63:0];
				ptr++;
			end
			for (int i = 0; i < n_win; i++) begin
				exp_w.data = pattern_mem[ptr][119:48];
				exp_w.layer_id = pattern_mem[ptr][41:32];
				exp_w.row_id = pattern_mem[ptr][25:16];
				exp_w.col_id = pattern_mem[ptr][9:0];
				exp_win_q.push_back(exp_w);
				ptr++;
			end
			// one window per row, layer and column
			check_value("window count", 128'(n_win), 128'(int'(test_cfg.num_rows)
				* int'(test_cfg.num_layers) * int'(test_cfg.num_cols)));
			queue_fetch_order(test_cfg);
			run_test(test_cfg);
		end
		if (exp_win_q.size() == 0 && exp_ar_q.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			report_failure("windows or bursts still expected at the end of the run");
		end
	end

	// --------------------------------------------------
	// AXI read slave model
	// --------------------------------------------------
	initial begin
		int ar_delay;
		int beat;
		logic [31:0] burst_q [$];
		logic [31:0] beat_addr;
		arready = 1'b0;
		rvalid = 1'b0;
		r = '0;
		ar_delay = 0;
		beat = 0;
		forever begin
			@(posedge clk);
			if (!reset_n) begin
				arready <= 1'b0;
				rvalid <= 1'b0;
				burst_q.delete();
				beat = 0;
				ar_delay = int'($urandom_range(3, 0));
			end else begin
				// address handshake is checked against the scan order
				if (arvalid && arready) begin
					if (exp_ar_q.size() == 0) begin
						report_failure("read burst issued with no burst expected");
					end else begin
						check_value("ar.addr", 128'(ar.addr), 128'(exp_ar_q.pop_front()));
						check_value("ar.len", 128'(ar.len), 128'd7);
						check_value("ar.size", 128'(ar.size), 128'd3);
						check_value("ar.burst", 128'(ar.burst), 128'd1);
					end
					burst_q.push_back(ar.addr);
					arready <= 1'b0;
					ar_delay = int'($urandom_range(3, 0));
				end else if (arvalid) begin
					if (ar_delay == 0) begin
						arready <= 1'b1;
					end else begin
						ar_delay--;
					end
				end
				// data beats
				if (rvalid && rready) begin
					if (beat == BEATS_PER_ROW - 1) begin
						burst_q.delete(0);
						beat = 0;
					end else begin
						beat++;
					end
				end
				// a beat on offer stays until taken
				if (!rvalid || rready) begin
					if (burst_q.size() != 0 && $urandom_range(3, 0) != 0) begin
						beat_addr = burst_q[0] + 32'(beat * 8);
						r.data <= read_word(beat_addr);
						r.resp <= 2'b00;
						r.last <= (beat == BEATS_PER_ROW - 1);
						rvalid <= 1'b1;
					end else begin
						rvalid <= 1'b0;
					end
				end
			end
		end
	end

	// random stalls on the window stream
	initial begin
		win_ready = 1'b0;
		forever begin
			@(posedge clk);
			win_ready <= $urandom_range(2, 0) != 0;
		end
	end

	// --------------------------------------------------
	// window monitor
	// --------------------------------------------------
	logic    hold_pending = 1'b0;
	window_t held_win;

	always @(posedge clk) begin
		window_t exp_w;
		if (!reset_n) begin
			hold_pending = 1'b0;
		end else begin
			// stalled window must not move
			if (hold_pending) begin
				check_value("win_valid", 128'(win_valid), 128'd1);
				check_value("win", 128'(win), 128'(held_win));
			end
			if (win_valid && win_ready) begin
				if (exp_win_q.size() == 0) begin
					report_failure("window transferred with no window expected");
				end else begin
					exp_w = exp_win_q.pop_front();
					check_value("win.data", 128'(win.data), 128'(exp_w.data));
					check_value("win.layer_id", 128'(win.layer_id), 128'(exp_w.layer_id));
					check_value("win.row_id", 128'(win.row_id), 128'(exp_w.row_id));
					check_value("win.col_id", 128'(win.col_id), 128'(exp_w.col_id));
					check_value("done", 128'(done), 128'd0);
				end
			end
			hold_pending = win_valid && !win_ready;
			held_win = win;
		end
	end

	// cycle limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
			report_failure($sformatf("timeout: run did not finish within %0d cycles",
				cycle_limit));
		end
	end

endmodule

//--- tb/window_patterns.hex
// first line holds the test count, then per test a config, memory words, windows
// config: base(8) layers(4) rows(4) cols(4) mem_words(4) windows(4) 0000
// memory: addr(8) 00000000 data(16); window: 00 data(18) layer(4) row(4) col(4)
00000000000000000000000000000003
// two layers, two rows, three columns
000100000002000200030004000c0000
00010000000000000000000000030201
00010040000000000000000000131211
00011000000000000000000000232221
00011040000000000000000000333231
00000000000102001112000000000000
00000000010203111213000000000001
00000000020300121300000000000002
00000000002122003132000100000000
00000000212223313233000100000001
00000000222300323300000100000002
00000102001112000000000000010000
00010203111213000000000000010001
00020300121300000000000000010002
00002122003132000000000100010000
00212223313233000000000100010001
00222300323300000000000100010002
// single row, single column
00200000000100010001000100010000
002000000000000000000000000000a5
0000000000a500000000000000000000
// one layer, two rows, nine columns across a beat boundary
00003000000100020009000400120000
00003000000000004746454443424140
00003008000000000000000000000048
00003040000000005756555453525150
00003048000000000000000000000058
00000000004041005051000000000000
00000000404142505152000000000001
00000000414243515253000000000002
00000000424344525354000000000003
00000000434445535455000000000004
00000000444546545556000000000005
00000000454647555657000000000006
00000000464748565758000000000007
00000000474800575800000000000008
00004041005051000000000000010000
00404142505152000000000000010001
00414243515253000000000000010002
00424344525354000000000000010003
00434445535455000000000000010004
00444546545556000000000000010005
00454647555657000000000000010006
00464748565758000000000000010007
00474800575800000000000000010008
